//--- flist.f
hdl/snn_pkg.sv
hdl/neuron_cfg_if.sv
hdl/spike_mac.sv
hdl/weight_mem.sv
hdl/neuron_cfg.sv
hdl/lif_neuron_array.sv
hdl/snn_layer.sv
tb/tb_clock_gen.sv
tb/snn_layer_tb.sv

//--- hdl/lif_neuron_array.sv
// Walks the four neurons one per cycle after an accepted step
// Result appears 5 edges after acceptance; steps while busy or disabled are dropped
`default_nettype none

module lif_neuron_array import snn_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               step,
    input  logic [N_LANES-1:0] spike_in,
    neuron_cfg_if.cfg_dst      cfg,
    output neuron_idx_t        rd_row,
    input  weight_row_t        rd_data,
    output logic [N_NEURONS-1:0] spike_out,
    output logic               out_valid,
    output logic               busy
);

    weight_t v_mem [N_NEURONS];      // Membrane potentials

    logic [N_LANES-1:0]   spikes_q;
    logic [N_NEURONS-1:0] fire_shadow;
    neuron_idx_t          cnt;
    logic                 pub_pending;
    logic                 accept;

    weight_t           mac_sum;
    logic [WEIGHT_W:0] raw_sum;
    weight_t           integ;
    weight_t           leaked;
    logic              fire;

    assign accept = step && !busy && cfg.enable;
    assign rd_row = cnt;

    spike_mac spike_mac_inst (
        .spike_in (spikes_q),
        .weight   (rd_data),
        .sum      (mac_sum)
    );

    // Membrane update for the neuron under cnt
    always_comb begin
        raw_sum = {1'b0, v_mem[cnt]} + {1'b0, mac_sum};
        integ   = raw_sum[WEIGHT_W] ? '1 : raw_sum[WEIGHT_W-1:0];   // Saturate
        leaked  = (integ > cfg.leak) ? integ - cfg.leak : '0;       // Floor at zero
        fire    = (leaked >= cfg.threshold);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy        <= 1'b0;
            cnt         <= '0;
            pub_pending <= 1'b0;
            out_valid   <= 1'b0;
            spike_out   <= '0;
            for (int n = 0; n < N_NEURONS; n++) begin
                v_mem[n] <= '0;
            end
        end else begin
            out_valid <= 1'b0;

            if (accept) begin
                spikes_q <= spike_in;
                busy     <= 1'b1;
                cnt      <= '0;
            end else if (busy) begin
                v_mem[cnt]       <= fire ? '0 : leaked;
                fire_shadow[cnt] <= fire;
                cnt              <= cnt + 1'b1;
                if (cnt == neuron_idx_t'(N_NEURONS - 1)) begin
                    busy        <= 1'b0;
                    pub_pending <= 1'b1;
                end
            end

            // Dropped while a timestep is running
            if (cfg.clear && !busy) begin
                for (int n = 0; n < N_NEURONS; n++) begin
                    v_mem[n] <= '0;
                end
            end

            if (pub_pending) begin
                spike_out   <= fire_shadow;
                out_valid   <= 1'b1;
                pub_pending <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/neuron_cfg.sv
// Register block for threshold, leak, enable and clear
// Address 3 is ignored; clear self-clears after one cycle
`default_nettype none

module neuron_cfg import snn_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      cfg_wr,
    input  cfg_addr_t cfg_addr,
    input  weight_t   cfg_data,
    neuron_cfg_if.cfg_src cfg
);

    logic wr_threshold;
    logic wr_leak;
    logic wr_control;

    assign wr_threshold = cfg_wr && (cfg_addr == CFG_THRESHOLD);
    assign wr_leak      = cfg_wr && (cfg_addr == CFG_LEAK);
    assign wr_control   = cfg_wr && (cfg_addr == CFG_CONTROL);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg.threshold <= '1;    // Nothing fires until programmed
            cfg.leak      <= '0;
            cfg.enable    <= 1'b0;
            cfg.clear     <= 1'b0;
        end else begin
            if (wr_threshold) begin
                cfg.threshold <= cfg_data;
            end
            if (wr_leak) begin
                cfg.leak <= cfg_data;
            end
            if (wr_control) begin
                cfg.enable <= cfg_data[CTRL_ENABLE];
            end
            // Pulse only, never stored
            cfg.clear <= wr_control && cfg_data[CTRL_CLEAR];
        end
    end

endmodule

`default_nettype wire

//--- hdl/neuron_cfg_if.sv
// Settings shared by all neurons; clear is a single-cycle pulse
`default_nettype none

interface neuron_cfg_if import snn_pkg::*; ();

    weight_t threshold;
    weight_t leak;
    logic    enable;     // Level
    logic    clear;      // One cycle wide

    modport cfg_src (
        output threshold,
        output leak,
        output enable,
        output clear
    );

    modport cfg_dst (
        input threshold,
        input leak,
        input enable,
        input clear
    );

endinterface

`default_nettype wire

//--- hdl/snn_layer.sv
// One spiking layer, 4 input lanes by 4 LIF neurons
// Plain strobes only; results are pulses with no back-pressure
`default_nettype none

module snn_layer import snn_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,

    input  logic                 wr_en,
    input  weight_addr_t         wr_addr,
    input  weight_t              wr_data,

    input  logic                 cfg_wr,
    input  cfg_addr_t            cfg_addr,
    input  weight_t              cfg_data,

    input  logic                 step,
    input  logic [N_LANES-1:0]   spike_in,

    output logic [N_NEURONS-1:0] spike_out,
    output logic                 out_valid,
    output logic                 busy
);

    neuron_idx_t rd_row;
    weight_row_t rd_data;

    neuron_cfg_if cfg_bus ();

    neuron_cfg neuron_cfg_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .cfg_wr   (cfg_wr),
        .cfg_addr (cfg_addr),
        .cfg_data (cfg_data),
        .cfg      (cfg_bus.cfg_src)
    );

    weight_mem weight_mem_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_row  (rd_row),
        .rd_data (rd_data)
    );

    lif_neuron_array lif_neuron_array_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .step      (step),
        .spike_in  (spike_in),
        .cfg       (cfg_bus.cfg_dst),
        .rd_row    (rd_row),
        .rd_data   (rd_data),
        .spike_out (spike_out),
        .out_valid (out_valid),
        .busy      (busy)
    );

endmodule

`default_nettype wire

//--- hdl/snn_pkg.sv
// Sizes are fixed for a 4x4 layer; weights and potentials are unsigned
// Lane 0 of a weight row sits in the low word
`default_nettype none

package snn_pkg;

    localparam int N_LANES   = 4;
    localparam int N_NEURONS = 4;
    localparam int WEIGHT_W  = 32;
    localparam int ROW_W     = N_LANES * WEIGHT_W;

    typedef logic [WEIGHT_W-1:0] weight_t;
    typedef weight_t [N_LANES-1:0] weight_row_t;   // [0] is the low word

    typedef logic [$clog2(N_NEURONS)-1:0] neuron_idx_t;
    typedef logic [$clog2(N_NEURONS*N_LANES)-1:0] weight_addr_t;   // {neuron, lane}

    typedef logic [1:0] cfg_addr_t;

    localparam cfg_addr_t CFG_THRESHOLD = 2'd0;
    localparam cfg_addr_t CFG_LEAK      = 2'd1;
    localparam cfg_addr_t CFG_CONTROL   = 2'd2;

    // Bits of the control register
    localparam int CTRL_ENABLE = 0;
    localparam int CTRL_CLEAR  = 1;

endpackage

`default_nettype wire

//--- hdl/spike_mac.sv
// Combinational sum of the weights on spiking lanes
// Result wraps modulo 2^WEIGHT_W
`default_nettype none

module spike_mac import snn_pkg::*; (
    input  logic [N_LANES-1:0] spike_in,
    input  weight_row_t        weight,
    output weight_t            sum
);

    weight_t masked [N_LANES];

    // Each lane kept only if its spike bit is set
    always_comb begin
        for (int i = 0; i < N_LANES; i++) begin
            masked[i] = weight[i] & {WEIGHT_W{spike_in[i]}};
        end
    end

    always_comb begin
        sum = '0;
        for (int i = 0; i < N_LANES; i++) begin
            sum = sum + masked[i];
        end
    end

endmodule

`default_nettype wire

//--- hdl/weight_mem.sv
// Sixteen weight words, cleared by reset; a write lands on the next edge
// Whole-row read is combinational, so a write during a timestep alters its sum
`default_nettype none

module weight_mem import snn_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         wr_en,
    input  weight_addr_t wr_addr,
    input  weight_t      wr_data,
    input  neuron_idx_t  rd_row,
    output weight_row_t  rd_data
);

    logic [ROW_W-1:0] rows [N_NEURONS];

    neuron_idx_t               wr_row;
    logic [$clog2(N_LANES)-1:0] wr_lane;

    // Upper address bits pick the neuron, lower bits the lane
    assign wr_row  = wr_addr[$bits(weight_addr_t)-1 -: $bits(neuron_idx_t)];
    assign wr_lane = wr_addr[$clog2(N_LANES)-1:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < N_NEURONS; r++) begin
                rows[r] <= '0;
            end
        end else if (wr_en) begin
            rows[wr_row][wr_lane*WEIGHT_W +: WEIGHT_W] <= wr_data;
        end
    end

    assign rd_data = rows[rd_row];

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing --top-module snn_layer_tb -f flist.f -o snn_sim \
    && ./obj_dir/snn_sim \
    || exit 1

//--- tb/snn_layer_tb.sv
// Directed tests for the 4x4 LIF layer against a software model
// Weights stay below 2^28 so timestep sums never wrap
`default_nettype none

module snn_layer_tb import snn_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TEST_CYCLES     = 80 * 7 + 70 * 2;   // Steps plus register writes
    localparam int WATCHDOG_CYCLES = TEST_CYCLES + 300;

    logic clk, rst_n;
    logic wr_en, cfg_wr, step;
    weight_addr_t wr_addr;
    weight_t wr_data, cfg_data;
    cfg_addr_t cfg_addr;
    logic [N_LANES-1:0] spike_in;
    logic [N_NEURONS-1:0] spike_out;
    logic out_valid, busy;

    // Model state
    weight_t m_w [N_NEURONS][N_LANES];
    weight_t m_v [N_NEURONS];
    weight_t m_thr, m_leak;
    int seed;

    tb_clock_gen clock_gen_inst (.clk(clk), .rst_n(rst_n));

    snn_layer snn_layer_inst (
        .clk(clk), .rst_n(rst_n),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .cfg_wr(cfg_wr), .cfg_addr(cfg_addr), .cfg_data(cfg_data),
        .step(step), .spike_in(spike_in),
        .spike_out(spike_out), .out_valid(out_valid), .busy(busy)
    );

    task automatic fail_and_stop(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_val(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
        if (actual !== expected) begin
            fail_and_stop($sformatf("mismatch at %0t: %s is %0h, expected %0h",
                                    $time, name, actual, expected));
        end
    endtask

    // Membrane rule with saturation, leak floor and reset on fire
    task automatic model_step(input logic [N_LANES-1:0] vec, output logic [N_NEURONS-1:0] fired);
        weight_t s, t, nv;
        logic [WEIGHT_W:0] wide;
        fired = '0;
        for (int n = 0; n < N_NEURONS; n++) begin
            s = '0;
            for (int l = 0; l < N_LANES; l++) begin
                if (vec[l]) s = s + m_w[n][l];
            end
            wide = {1'b0, m_v[n]} + {1'b0, s};
            t    = wide[WEIGHT_W] ? '1 : wide[WEIGHT_W-1:0];
            nv   = (t > m_leak) ? t - m_leak : '0;
            fired[n] = (nv >= m_thr);
            m_v[n]   = fired[n] ? '0 : nv;
        end
    endtask

    task automatic write_weight(input int n, input int l, input weight_t w);
        @(negedge clk);
        wr_en   = 1'b1;
        wr_addr = weight_addr_t'(n * N_LANES + l);
        wr_data = w;
        @(negedge clk);
        wr_en    = 1'b0;
        m_w[n][l] = w;
    endtask

    task automatic write_cfg(input cfg_addr_t a, input weight_t d);
        @(negedge clk);
        cfg_wr   = 1'b1;
        cfg_addr = a;
        cfg_data = d;
        @(negedge clk);
        cfg_wr = 1'b0;
        if (a == CFG_THRESHOLD) m_thr = d;
        if (a == CFG_LEAK) m_leak = d;
        if (a == CFG_CONTROL && d[CTRL_CLEAR]) begin
            for (int n = 0; n < N_NEURONS; n++) m_v[n] = '0;
        end
    endtask

    task automatic step_and_check(input logic [N_LANES-1:0] vec);
        logic [N_NEURONS-1:0] want;
        int waited;
        model_step(vec, want);
        @(negedge clk);
        step     = 1'b1;
        spike_in = vec;
        @(negedge clk);
        step = 1'b0;
        for (waited = 1; waited <= 5; waited++) begin
            @(negedge clk);
            if (out_valid === 1'b1) break;
        end
        if (waited > 5) fail_and_stop("no result: out_valid did not arrive within 5 cycles");
        check_val("spike_out", 32'(spike_out), 32'(want));
    endtask

    task automatic reset_defaults();
        check_val("busy", 32'(busy), 32'd0);
        check_val("out_valid", 32'(out_valid), 32'd0);
        check_val("spike_out", 32'(spike_out), 32'd0);
        step     = 1'b1;   // Enable still low
        spike_in = 4'hf;
        @(negedge clk);
        step = 1'b0;
        repeat (8) begin
            @(negedge clk);
            check_val("out_valid", 32'(out_valid), 32'd0);
        end
    endtask

    task automatic lane_masking();
        logic [N_LANES-1:0] vec;
        logic [N_NEURONS-1:0] want;
        write_cfg(CFG_THRESHOLD, 32'd1);
        write_cfg(CFG_LEAK, 32'd0);
        write_cfg(CFG_CONTROL, 32'h1);
        // Neuron n listens only on lane 3-n
        for (int n = 0; n < N_NEURONS; n++) begin
            for (int l = 0; l < N_LANES; l++) begin
                write_weight(n, l, (l == N_LANES - 1 - n) ? weight_t'(16 * (n + 1)) : '0);
            end
        end
        for (int l = 0; l < N_LANES; l++) begin
            vec = '0;
            vec[l] = 1'b1;
            want = '0;
            want[N_NEURONS-1-l] = 1'b1;
            step_and_check(vec);
            check_val("spike_out", 32'(spike_out), 32'(want));
        end
        step_and_check('0);
        check_val("spike_out", 32'(spike_out), 32'd0);
    endtask

    task automatic integrate_and_fire();
        write_cfg(CFG_CONTROL, 32'h3);
        write_cfg(CFG_THRESHOLD, 32'd100);
        for (int n = 0; n < N_NEURONS; n++) begin
            for (int l = 0; l < N_LANES; l++) begin
                write_weight(n, l, (l == 0) ? weight_t'(15 + 10 * n) : (l == 1) ? 32'd7 : '0);
            end
        end
        repeat (10) step_and_check(4'b0011);   // Sums 22..52 fire after 2 to 5 steps
    endtask

    task automatic leak_and_floor();
        write_cfg(CFG_CONTROL, 32'h3);
        write_cfg(CFG_THRESHOLD, 32'd200);
        write_cfg(CFG_LEAK, 32'd1000);
        repeat (4) begin
            step_and_check(4'b1111);
            check_val("spike_out", 32'(spike_out), 32'd0);
        end
        write_cfg(CFG_LEAK, 32'd5);
        repeat (8) step_and_check(4'b1111);
    endtask

    task automatic step_timing();
        logic [N_NEURONS-1:0] want;
        int pulses, first;
        write_cfg(CFG_CONTROL, 32'h3);
        write_cfg(CFG_THRESHOLD, 32'd30);
        model_step(4'b0011, want);
        @(negedge clk);
        step     = 1'b1;
        spike_in = 4'b0011;
        @(negedge clk);
        check_val("busy", 32'(busy), 32'd1);   // Step still high and must be ignored
        @(negedge clk);
        step   = 1'b0;
        pulses = 0;
        first  = 0;
        for (int i = 2; i <= 11; i++) begin
            @(negedge clk);
            if (out_valid === 1'b1) begin
                pulses++;
                if (first == 0) first = i;
            end
        end
        check_val("out_valid delay", 32'(first), 32'd5);
        check_val("out_valid pulses", 32'(pulses), 32'd1);
        check_val("spike_out", 32'(spike_out), 32'(want));
    endtask

    task automatic random_steps_with_clear();
        write_cfg(CFG_CONTROL, 32'h3);
        for (int n = 0; n < N_NEURONS; n++) begin
            for (int l = 0; l < N_LANES; l++) begin
                write_weight(n, l, weight_t'($random(seed)) & 32'h0fff_ffff);
            end
        end
        write_cfg(CFG_THRESHOLD, (weight_t'($random(seed)) & 32'h1fff_ffff) | 32'h1);
        write_cfg(CFG_LEAK, weight_t'($random(seed)) & 32'h00ff_ffff);
        for (int i = 0; i < 50; i++) begin
            if (i == 25) write_cfg(CFG_CONTROL, 32'h3);   // Clear mid-run
            step_and_check(4'($random(seed)));
        end
    endtask

    initial begin
        wr_en    = 1'b0;
        wr_addr  = '0;
        wr_data  = '0;
        cfg_wr   = 1'b0;
        cfg_addr = '0;
        cfg_data = '0;
        step     = 1'b0;
        spike_in = '0;
        m_thr  = '1;
        m_leak = '0;
        for (int n = 0; n < N_NEURONS; n++) begin
            m_v[n] = '0;
            for (int l = 0; l < N_LANES; l++) m_w[n][l] = '0;
        end
        seed = 32'he7bf;
        wait (rst_n === 1'b1);
        @(negedge clk);
        reset_defaults();
        lane_masking();
        integrate_and_fire();
        leak_and_floor();
        step_timing();
        random_steps_with_clear();
        $display("ALL TESTS PASSED");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        fail_and_stop("watchdog timeout: the tests did not finish in time");
    end

endmodule

`default_nettype wire

//--- tb/tb_clock_gen.sv
// 40 ns clock; rst_n held low for 5 cycles, released on a falling edge
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire
